/* tqv_periph_defines.svh */
// Peripheral wrapper parameters: bus widths, slot counts and GPIO register map
`ifndef TQV_PERIPH_DEFINES_SVH
`define TQV_PERIPH_DEFINES_SVH

// Core data bus
`define TQV_ADDR_W          11
`define TQV_DATA_W          32

// Peripheral slots
`define TQV_USER_SLOTS      8   // 64 bytes each from 0x000
`define TQV_SIMPLE_SLOTS    4   // 16 bytes each from 0x400

// Output PMOD
`define TQV_PINS            8

// Fixed slot assignments
`define TQV_SLOT_GPIO       1
`define TQV_SLOT_UART       2   // Drives pins 0 and 1 out of reset

// GPIO register offsets within slot 1
`define TQV_GPIO_OUT_OFS    6'h00
`define TQV_GPIO_IN_OFS     6'h04
`define TQV_GPIO_AUDIO_OFS  6'h10
`define TQV_GPIO_FUNC_OFS   6'h20   // One word per pin, stride 4

`endif

/* tqv_bus_pkg.sv */
// Core bus types: access sizes and the request and response records on each side of decode
`include "tqv_periph_defines.svh"

package tqv_bus_pkg;

    // Size code as driven by the core, 11 means idle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_e;

    // Request from the core, 47 bits
    typedef struct packed {
        logic [`TQV_ADDR_W-1:0] addr;
        logic [`TQV_DATA_W-1:0] wdata;
        access_size_e           write_size;
        access_size_e           read_size;
    } bus_req_t;

    // Request to one full-interface slot, 42 bits
    typedef struct packed {
        logic [5:0]             offset;     // Byte offset inside the 64 byte window
        logic [`TQV_DATA_W-1:0] wdata;
        access_size_e           write_size; // NONE unless this slot is selected
        access_size_e           read_size;
    } slot_req_t;

    // Answer from one full-interface slot
    typedef struct packed {
        logic [`TQV_DATA_W-1:0] rdata;
        logic                   ready;
    } slot_rsp_t;

    // Request to one byte-wide simple slot, 13 bits
    typedef struct packed {
        logic [3:0] offset;
        logic [7:0] wdata;
        logic       write;  // Selected and writing
    } simple_req_t;

endpackage

/* tqv_pin_pkg.sv */
// Pin side types: per-pin output function word and audio tap codes
`include "tqv_periph_defines.svh"

package tqv_pin_pkg;

    // Output function of one pin
    typedef struct packed {
        logic       simple; // Source is a simple slot
        logic [3:0] slot;   // Slot index within that bank
    } pin_func_t;

    // Audio tap, one per code
    typedef enum logic [2:0] {
        AUDIO_USER2_B7   = 3'd0,
        AUDIO_USER3_B7   = 3'd1,
        AUDIO_SIMPLE0_B0 = 3'd2,
        AUDIO_SIMPLE1_B7 = 3'd3,
        AUDIO_USER4_B7   = 3'd4,
        AUDIO_SIMPLE2_B7 = 3'd5,
        AUDIO_USER5_B6   = 3'd6,
        AUDIO_USER7_B7   = 3'd7
    } audio_src_e;

    // Function word loaded at reset
    // Pins 0 and 1 carry the UART, the rest follow GPIO
    function automatic pin_func_t reset_pin_func(input int unsigned pin);
        pin_func_t f;
        f.simple = 1'b0;
        f.slot   = (pin < 2) ? 4'(`TQV_SLOT_UART) : 4'(`TQV_SLOT_GPIO);
        return f;
    endfunction

endpackage

/* tqv_periph_decode.sv */
// Address decode: selects one slot, gates its request and returns its response
`timescale 1ns/1ps
`include "tqv_periph_defines.svh"

module tqv_periph_decode (
    input  tqv_bus_pkg::bus_req_t    i_bus_req,
    input  logic                     i_read_mask,
    output tqv_bus_pkg::slot_req_t   o_user_req    [`TQV_USER_SLOTS],
    output tqv_bus_pkg::simple_req_t o_simple_req  [`TQV_SIMPLE_SLOTS],
    input  tqv_bus_pkg::slot_rsp_t   i_gpio_rsp,
    input  tqv_bus_pkg::slot_rsp_t   i_user_rsp    [`TQV_USER_SLOTS],
    input  logic [7:0]               i_simple_data [`TQV_SIMPLE_SLOTS],
    output tqv_bus_pkg::slot_rsp_t   o_sel_rsp
);

    localparam int USER_IDX_W   = $clog2(`TQV_USER_SLOTS);
    localparam int SIMPLE_IDX_W = $clog2(`TQV_SIMPLE_SLOTS);

    logic                               user_hit;
    logic                               simple_hit;
    logic [USER_IDX_W-1:0]              user_idx;
    logic [SIMPLE_IDX_W-1:0]            simple_idx;
    logic [`TQV_USER_SLOTS-1:0]         user_sel;
    logic [`TQV_SIMPLE_SLOTS-1:0]       simple_sel;
    logic                               write_req;
    tqv_bus_pkg::access_size_e          slot_read_size;

    assign user_hit   = (i_bus_req.addr[10:9] == 2'b00);    // 0x000 - 0x1FF
    assign simple_hit = (i_bus_req.addr[10:6] == 5'b10000); // 0x400 - 0x43F
    assign user_idx   = i_bus_req.addr[6 +: USER_IDX_W];
    assign simple_idx = i_bus_req.addr[4 +: SIMPLE_IDX_W];

    assign write_req  = (i_bus_req.write_size != tqv_bus_pkg::SIZE_NONE);

    // No new read while the previous result is being returned
    assign slot_read_size = i_read_mask ? tqv_bus_pkg::SIZE_NONE : i_bus_req.read_size;

    for (genvar k = 0; k < `TQV_USER_SLOTS; k++) begin : g_user
        assign user_sel[k] = user_hit && (user_idx == k);

        assign o_user_req[k].offset     = i_bus_req.addr[5:0];
        assign o_user_req[k].wdata      = i_bus_req.wdata;
        assign o_user_req[k].write_size = user_sel[k] ? i_bus_req.write_size
                                                      : tqv_bus_pkg::SIZE_NONE;
        assign o_user_req[k].read_size  = user_sel[k] ? slot_read_size
                                                      : tqv_bus_pkg::SIZE_NONE;
    end

    for (genvar k = 0; k < `TQV_SIMPLE_SLOTS; k++) begin : g_simple
        assign simple_sel[k] = simple_hit && (simple_idx == k);

        assign o_simple_req[k].offset = i_bus_req.addr[3:0];
        assign o_simple_req[k].wdata  = i_bus_req.wdata[7:0];
        assign o_simple_req[k].write  = simple_sel[k] && write_req;
    end

    // Response of the selected slot
    always_comb begin
        o_sel_rsp.rdata = '0;
        o_sel_rsp.ready = 1'b1;     // Unused ranges answer at once
        if (|simple_sel) begin
            o_sel_rsp.rdata = {{(`TQV_DATA_W-8){1'b0}}, i_simple_data[simple_idx]};
        end else if (|user_sel) begin
            if (user_idx == `TQV_SLOT_GPIO) begin
                o_sel_rsp = i_gpio_rsp;
            end else if (user_idx != 0) begin
                o_sel_rsp = i_user_rsp[user_idx];
            end
            // Slot 0 is reserved and reads zero
        end
    end

endmodule

/* tqv_read_return.sv */
// Read return path: registers slot data, holds it for the core and drives ready
`timescale 1ns/1ps
`include "tqv_periph_defines.svh"

module tqv_read_return (
    input  logic                            clk,
    input  logic                            rst_n,
    input  tqv_bus_pkg::access_size_e       i_read_size,
    input  tqv_bus_pkg::access_size_e       i_write_size,
    input  tqv_bus_pkg::slot_rsp_t          i_sel_rsp,
    input  logic                            i_data_read_complete,
    output logic [`TQV_DATA_W-1:0]          o_data_out,
    output logic                            o_data_ready,
    output logic                            o_read_mask
);

    logic                   read_req;
    logic                   capture;
    logic                   data_hold;
    logic                   ready_r;
    logic [`TQV_DATA_W-1:0] data_r;

    assign read_req = (i_read_size != tqv_bus_pkg::SIZE_NONE);

    // Take the slot's data once, then keep it until the core is done
    assign capture  = read_req && i_sel_rsp.ready && !data_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold <= 1'b0;
            ready_r   <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                data_hold <= 1'b0;
            end
            if (capture) begin
                data_hold <= 1'b1;      // Wins over a same cycle complete
            end
            ready_r <= read_req && i_sel_rsp.ready;    // Follows the data register
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_sel_rsp.rdata;
        end
    end

    assign o_data_out   = data_r;
    assign o_data_ready = ready_r || (i_write_size != tqv_bus_pkg::SIZE_NONE);

    // Suppress a second slot read while ready is up
    assign o_read_mask  = ready_r;

endmodule

/* tqv_gpio_regs.sv */
// GPIO slot: output byte, input readback, pin function selects and audio select
`timescale 1ns/1ps
`include "tqv_periph_defines.svh"

module tqv_gpio_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  tqv_bus_pkg::slot_req_t      i_req,
    input  logic [7:0]                  i_ui_in,
    output tqv_bus_pkg::slot_rsp_t      o_rsp,
    output logic [7:0]                  o_gpio_out,
    output tqv_pin_pkg::pin_func_t      o_pin_func [`TQV_PINS],
    output tqv_pin_pkg::audio_src_e     o_audio_src,
    output logic                        o_audio_select
);

    localparam int FUNC_IDX_W = $clog2(`TQV_PINS);

    logic [7:0]                 gpio_out;
    tqv_pin_pkg::pin_func_t     pin_func [`TQV_PINS];
    tqv_pin_pkg::audio_src_e    audio_src;
    logic                       audio_en;

    logic                       wr_en;
    logic                       func_hit;
    logic [FUNC_IDX_W-1:0]      func_idx;
    logic [`TQV_DATA_W-1:0]     rdata;

    // Request sizes arrive already gated by the decoder
    assign wr_en    = (i_req.write_size != tqv_bus_pkg::SIZE_NONE);

    // Function words at 0x20, 0x24 .. 0x3C
    assign func_hit = ((i_req.offset & 6'h23) == `TQV_GPIO_FUNC_OFS);
    assign func_idx = i_req.offset[2 +: FUNC_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_en  <= 1'b0;
            audio_src <= tqv_pin_pkg::AUDIO_USER2_B7;
            for (int n = 0; n < `TQV_PINS; n++) begin
                pin_func[n] <= tqv_pin_pkg::reset_pin_func(n);
            end
        end else if (wr_en) begin
            // Any access size writes from the low bits
            if (i_req.offset == `TQV_GPIO_OUT_OFS) begin
                gpio_out <= i_req.wdata[7:0];
            end
            if (i_req.offset == `TQV_GPIO_AUDIO_OFS) begin
                audio_en  <= i_req.wdata[3];
                audio_src <= tqv_pin_pkg::audio_src_e'(i_req.wdata[2:0]);
            end
            if (func_hit) begin
                pin_func[func_idx] <= tqv_pin_pkg::pin_func_t'(i_req.wdata[4:0]);
            end
        end
    end

    // Readback, zero extended
    always_comb begin
        rdata = '0;
        if (i_req.offset == `TQV_GPIO_OUT_OFS) begin
            rdata[7:0] = gpio_out;
        end else if (i_req.offset == `TQV_GPIO_IN_OFS) begin
            rdata[7:0] = i_ui_in;
        end else if (i_req.offset == `TQV_GPIO_AUDIO_OFS) begin
            rdata[3:0] = {audio_en, audio_src};
        end else if (func_hit) begin
            rdata[4:0] = pin_func[func_idx];
        end
    end

    assign o_rsp.rdata    = rdata;
    assign o_rsp.ready    = 1'b1;   // Register reads never stall

    assign o_gpio_out     = gpio_out;
    assign o_pin_func     = pin_func;
    assign o_audio_src    = audio_src;
    assign o_audio_select = audio_en;

endmodule

/* tqv_pin_mux.sv */
// Output pin routing from the selected slots and the registered audio tap
`timescale 1ns/1ps
`include "tqv_periph_defines.svh"

module tqv_pin_mux (
    input  logic                    clk,
    input  tqv_pin_pkg::pin_func_t  i_pin_func  [`TQV_PINS],
    input  tqv_pin_pkg::audio_src_e i_audio_src,
    input  logic [7:0]              i_gpio_out,
    input  logic [7:0]              i_user_uo   [`TQV_USER_SLOTS],
    input  logic [7:0]              i_simple_uo [`TQV_SIMPLE_SLOTS],
    output logic [7:0]              o_uo_out,
    output logic                    o_audio
);

    localparam int USER_IDX_W   = $clog2(`TQV_USER_SLOTS);
    localparam int SIMPLE_IDX_W = $clog2(`TQV_SIMPLE_SLOTS);

    // Pin n takes bit n of its chosen source
    for (genvar n = 0; n < `TQV_PINS; n++) begin : g_pin
        always_comb begin
            o_uo_out[n] = 1'b0;
            if (i_pin_func[n].simple) begin
                if (i_pin_func[n].slot < `TQV_SIMPLE_SLOTS) begin
                    o_uo_out[n] = i_simple_uo[i_pin_func[n].slot[SIMPLE_IDX_W-1:0]][n];
                end
            end else if (i_pin_func[n].slot == `TQV_SLOT_GPIO) begin
                o_uo_out[n] = i_gpio_out[n];
            end else if (i_pin_func[n].slot != 0 &&
                         i_pin_func[n].slot < `TQV_USER_SLOTS) begin
                o_uo_out[n] = i_user_uo[i_pin_func[n].slot[USER_IDX_W-1:0]][n];
            end
            // Slot 0 and missing slots stay low
        end
    end

    // Audio tap, one cycle behind its source
    always_ff @(posedge clk) begin
        case (i_audio_src)
            tqv_pin_pkg::AUDIO_USER2_B7:   o_audio <= i_user_uo[2][7];
            tqv_pin_pkg::AUDIO_USER3_B7:   o_audio <= i_user_uo[3][7];
            tqv_pin_pkg::AUDIO_SIMPLE0_B0: o_audio <= i_simple_uo[0][0];
            tqv_pin_pkg::AUDIO_SIMPLE1_B7: o_audio <= i_simple_uo[1][7];
            tqv_pin_pkg::AUDIO_USER4_B7:   o_audio <= i_user_uo[4][7];
            tqv_pin_pkg::AUDIO_SIMPLE2_B7: o_audio <= i_simple_uo[2][7];
            tqv_pin_pkg::AUDIO_USER5_B6:   o_audio <= i_user_uo[5][6];  // Second channel
            tqv_pin_pkg::AUDIO_USER7_B7:   o_audio <= i_user_uo[7][7];
            default:                       o_audio <= 1'b0;
        endcase
    end

endmodule

/* tqv_periph_wrapper.sv */
// Peripheral wrapper top: core bus, GPIO, external slot ports and pin routing
`timescale 1ns/1ps
`include "tqv_periph_defines.svh"

module tqv_periph_wrapper (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [7:0]                  i_ui_in,
    input  tqv_bus_pkg::bus_req_t       i_bus_req,
    input  logic                        i_data_read_complete,
    output logic [`TQV_DATA_W-1:0]      o_data_out,
    output logic                        o_data_ready,
    output tqv_bus_pkg::slot_req_t      o_user_req    [2:`TQV_USER_SLOTS-1],
    input  tqv_bus_pkg::slot_rsp_t      i_user_rsp    [2:`TQV_USER_SLOTS-1],
    input  logic [7:0]                  i_user_uo     [2:`TQV_USER_SLOTS-1],
    output tqv_bus_pkg::simple_req_t    o_simple_req  [`TQV_SIMPLE_SLOTS],
    input  logic [7:0]                  i_simple_data [`TQV_SIMPLE_SLOTS],
    input  logic [7:0]                  i_simple_uo   [`TQV_SIMPLE_SLOTS],
    output logic [7:0]                  o_uo_out,
    output logic                        o_audio,
    output logic                        o_audio_select
);

    logic                       read_mask;
    tqv_bus_pkg::slot_req_t     user_req [`TQV_USER_SLOTS];
    tqv_bus_pkg::slot_rsp_t     user_rsp [`TQV_USER_SLOTS];
    logic [7:0]                 user_uo  [`TQV_USER_SLOTS];
    tqv_bus_pkg::slot_rsp_t     gpio_rsp;
    tqv_bus_pkg::slot_rsp_t     sel_rsp;
    logic [7:0]                 gpio_out;
    tqv_pin_pkg::pin_func_t     pin_func [`TQV_PINS];
    tqv_pin_pkg::audio_src_e    audio_src;

    // Slots 0 and 1 are internal, the rest come from the ports
    always_comb begin
        user_rsp[0] = '0;
        user_rsp[1] = '0;   // GPIO answers on its own port
        user_uo[0]  = '0;
        user_uo[1]  = '0;
        for (int k = 2; k < `TQV_USER_SLOTS; k++) begin
            user_rsp[k] = i_user_rsp[k];
            user_uo[k]  = i_user_uo[k];
        end
    end

    for (genvar k = 2; k < `TQV_USER_SLOTS; k++) begin : g_user_port
        assign o_user_req[k] = user_req[k];
    end

    tqv_periph_decode u_decode (
        .i_bus_req      (i_bus_req),
        .i_read_mask    (read_mask),
        .o_user_req     (user_req),
        .o_simple_req   (o_simple_req),
        .i_gpio_rsp     (gpio_rsp),
        .i_user_rsp     (user_rsp),
        .i_simple_data  (i_simple_data),
        .o_sel_rsp      (sel_rsp)
    );

    tqv_read_return u_read_return (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_read_size          (i_bus_req.read_size),
        .i_write_size         (i_bus_req.write_size),
        .i_sel_rsp            (sel_rsp),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_read_mask          (read_mask)
    );

    tqv_gpio_regs u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req          (user_req[`TQV_SLOT_GPIO]),
        .i_ui_in        (i_ui_in),
        .o_rsp          (gpio_rsp),
        .o_gpio_out     (gpio_out),
        .o_pin_func     (pin_func),
        .o_audio_src    (audio_src),
        .o_audio_select (o_audio_select)
    );

    tqv_pin_mux u_pin_mux (
        .clk         (clk),
        .i_pin_func  (pin_func),
        .i_audio_src (audio_src),
        .i_gpio_out  (gpio_out),
        .i_user_uo   (user_uo),
        .i_simple_uo (i_simple_uo),
        .o_uo_out    (o_uo_out),
        .o_audio     (o_audio)
    );

endmodule

/* tb_tqv_periph.sv */
// Testbench for the peripheral wrapper with slot models, a reference model and self-checks
`timescale 1ns/1ps
`include "tqv_periph_defines.svh"

module tb_tqv_periph;

    localparam int WRITE_CYC   = 2;
    localparam int READ_CYC    = `TQV_USER_SLOTS + 5;  // Worst slot latency plus hold and complete
    localparam int FUNC_ROUNDS = 16;
    localparam int TEST_CYC    = 10 + 12 * WRITE_CYC + 15 * READ_CYC
                               + FUNC_ROUNDS * (`TQV_PINS * WRITE_CYC + 2) + 8 * (WRITE_CYC + 3);
    localparam int TIMEOUT_CYC = 2 * TEST_CYC;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [7:0]                 ui_in;
    tqv_bus_pkg::bus_req_t      bus_req;
    logic                       data_read_complete;
    logic [`TQV_DATA_W-1:0]     data_out;
    logic                       data_ready;
    tqv_bus_pkg::slot_req_t     user_req    [2:`TQV_USER_SLOTS-1];
    tqv_bus_pkg::slot_rsp_t     user_rsp    [2:`TQV_USER_SLOTS-1];
    logic [7:0]                 user_uo     [2:`TQV_USER_SLOTS-1];
    tqv_bus_pkg::simple_req_t   simple_req  [`TQV_SIMPLE_SLOTS];
    logic [7:0]                 simple_data [`TQV_SIMPLE_SLOTS];
    logic [7:0]                 simple_uo   [`TQV_SIMPLE_SLOTS];
    logic [7:0]                 uo_out;
    logic                       audio;
    logic                       audio_select;

    // Slot model state
    logic [31:0]                user_reg      [2:`TQV_USER_SLOTS-1];
    int                         user_cnt      [2:`TQV_USER_SLOTS-1];
    int                         user_wr_count [2:`TQV_USER_SLOTS-1];
    tqv_bus_pkg::access_size_e  user_wr_size  [2:`TQV_USER_SLOTS-1];
    logic [5:0]                 user_wr_ofs   [2:`TQV_USER_SLOTS-1];
    int                         user_rd_count [2:`TQV_USER_SLOTS-1];
    logic [7:0]                 simple_reg    [`TQV_SIMPLE_SLOTS];
    logic [3:0]                 simple_wr_ofs [`TQV_SIMPLE_SLOTS];

    // Mirror of the GPIO registers
    logic [4:0]                 m_func [`TQV_PINS];
    logic [7:0]                 m_gpio;
    logic [3:0]                 m_audio;
    logic                       exp_audio;

    logic                       check_en = 1'b0;
    int                         checks = 0;
    int                         errors = 0;
    int                         cycle_count = 0;
    int                         wr_before [2:`TQV_USER_SLOTS-1];
    int                         rd_before;
    logic [31:0]                data;
    logic [5:0]                 offset;
    tqv_bus_pkg::access_size_e  size;

    tqv_periph_wrapper uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_bus_req            (bus_req),
        .i_data_read_complete (data_read_complete),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_user_req           (user_req),
        .i_user_rsp           (user_rsp),
        .i_user_uo            (user_uo),
        .o_simple_req         (simple_req),
        .i_simple_data        (simple_data),
        .i_simple_uo          (simple_uo),
        .o_uo_out             (uo_out),
        .o_audio              (audio),
        .o_audio_select       (audio_select)
    );

    always #2 clk = ~clk;   // 4 ns period

    // User slot k answers a read k-1 cycles after it starts and simple slots answer at once
    always @(posedge clk) begin
        for (int k = 2; k < `TQV_USER_SLOTS; k++) begin
            if (!rst_n) begin
                user_reg[k]      <= '0;
                user_cnt[k]      <= 0;
                user_wr_count[k] <= 0;
                user_wr_size[k]  <= tqv_bus_pkg::SIZE_NONE;
                user_wr_ofs[k]   <= '0;
                user_rd_count[k] <= 0;
            end else begin
                if (user_req[k].write_size != tqv_bus_pkg::SIZE_NONE) begin
                    user_reg[k]      <= user_req[k].wdata;
                    user_wr_size[k]  <= user_req[k].write_size;
                    user_wr_ofs[k]   <= user_req[k].offset;
                    user_wr_count[k] <= user_wr_count[k] + 1;
                end
                if (user_req[k].read_size != tqv_bus_pkg::SIZE_NONE && user_rsp[k].ready) begin
                    user_rd_count[k] <= user_rd_count[k] + 1;   // One finished slot read
                end
                user_cnt[k] <= (user_req[k].read_size != tqv_bus_pkg::SIZE_NONE) ?
                               user_cnt[k] + 1 : 0;
            end
        end
        for (int j = 0; j < `TQV_SIMPLE_SLOTS; j++) begin
            if (!rst_n) begin
                simple_reg[j]    <= '0;
                simple_wr_ofs[j] <= '0;
            end else if (simple_req[j].write) begin
                simple_reg[j]    <= simple_req[j].wdata;
                simple_wr_ofs[j] <= simple_req[j].offset;
            end
        end
    end

    always_comb begin
        for (int k = 2; k < `TQV_USER_SLOTS; k++) begin
            user_rsp[k].rdata = user_reg[k];
            user_rsp[k].ready = (user_cnt[k] >= k - 1);
        end
        for (int j = 0; j < `TQV_SIMPLE_SLOTS; j++) begin
            simple_data[j] = simple_reg[j];
        end
    end

    // Expected pin outputs from the mirrored function words
    function automatic logic [7:0] ref_pins();
        logic [7:0] pins;
        logic [4:0] f;
        pins = '0;
        for (int n = 0; n < `TQV_PINS; n++) begin
            f = m_func[n];
            if (f[4]) begin
                if (f[3:0] < `TQV_SIMPLE_SLOTS) pins[n] = simple_uo[f[1:0]][n];
            end else if (f[3:0] == 4'd1) begin
                pins[n] = m_gpio[n];
            end else if (f[3:0] >= 4'd2 && f[3:0] <= 4'd7) begin
                pins[n] = user_uo[f[2:0]][n];
            end
        end
        return pins;
    endfunction

    function automatic logic audio_tap(input logic [2:0] code);
        case (code)
            3'd0:    return user_uo[2][7];
            3'd1:    return user_uo[3][7];
            3'd2:    return simple_uo[0][0];
            3'd3:    return simple_uo[1][7];
            3'd4:    return user_uo[4][7];
            3'd5:    return simple_uo[2][7];
            3'd6:    return user_uo[5][6];
            default: return user_uo[7][7];
        endcase
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) exp_audio <= audio_tap(m_audio[2:0]);   // Registered like the DUT

    // Pins and audio compared every cycle against the reference
    always @(negedge clk) begin
        if (check_en) begin
            check(uo_out, ref_pins(), "pin outputs");
            check(audio, exp_audio, "audio tap");
            check(audio_select, m_audio[3], "audio select");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, the bus handshake never finished", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic shuffle_uo();
        for (int k = 2; k < `TQV_USER_SLOTS; k++) user_uo[k] = $urandom;
        for (int j = 0; j < `TQV_SIMPLE_SLOTS; j++) simple_uo[j] = $urandom;
    endtask

    task automatic bus_write(input logic [10:0] addr, input logic [31:0] wdata,
                             input tqv_bus_pkg::access_size_e wsize);
        bus_req.addr       = addr;
        bus_req.wdata      = wdata;
        bus_req.write_size = wsize;
        #1;
        check(data_ready, 1'b1, "write ready");
        step();
        bus_req.write_size = tqv_bus_pkg::SIZE_NONE;
    endtask

    task automatic gpio_write(input logic [5:0] ofs, input logic [31:0] wdata);
        bus_write({5'(`TQV_SLOT_GPIO), ofs}, wdata, random_size());
        if (ofs == `TQV_GPIO_OUT_OFS) m_gpio = wdata[7:0];
        if (ofs == `TQV_GPIO_AUDIO_OFS) m_audio = wdata[3:0];
        if (ofs[5] && ofs[1:0] == 2'b00) m_func[ofs[4:2]] = wdata[4:0];
    endtask

    // Read, then hold the request and delay the completion pulse
    task automatic bus_read(input logic [10:0] addr, input int exp_lat,
                            input logic [31:0] exp_data, input string what);
        int          lat;
        logic [31:0] first;
        bus_req.addr      = addr;
        bus_req.read_size = tqv_bus_pkg::SIZE_WORD;
        lat = 0;
        do begin
            step();
            lat++;
        end while (!data_ready);
        check(lat, exp_lat, {what, " latency"});
        check(data_out, exp_data, what);
        first = data_out;
        repeat (3) step();
        check(data_out, first, {what, " under back-pressure"});
        bus_req.read_size  = tqv_bus_pkg::SIZE_NONE;
        data_read_complete = 1'b1;
        step();
        data_read_complete = 1'b0;
        check(data_ready, 1'b0, {what, " ready after complete"});
    endtask

    function automatic tqv_bus_pkg::access_size_e random_size();
        return tqv_bus_pkg::access_size_e'(2'($urandom % 3));
    endfunction

    initial begin
        void'($urandom(32'hf15f));
        rst_n              = 1'b0;
        data_read_complete = 1'b0;
        bus_req.addr       = '0;
        bus_req.wdata      = '0;
        bus_req.write_size = tqv_bus_pkg::SIZE_NONE;
        bus_req.read_size  = tqv_bus_pkg::SIZE_NONE;
        ui_in              = $urandom;
        shuffle_uo();
        m_gpio  = '0;
        m_audio = '0;
        for (int n = 0; n < `TQV_PINS; n++) m_func[n] = (n < 2) ? 5'd2 : 5'd1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();
        check_en = 1'b1;

        // Reset routing, GPIO output and input readback
        check(uo_out, {6'b0, user_uo[2][1:0]}, "reset pin routing");
        data = $urandom;
        gpio_write(`TQV_GPIO_OUT_OFS, data);
        check(uo_out[7:2], data[7:2], "GPIO pins");
        bus_read(11'h040 | `TQV_GPIO_OUT_OFS, 1, {24'b0, data[7:0]}, "GPIO output readback");
        bus_read(11'h040 | `TQV_GPIO_IN_OFS, 1, {24'b0, ui_in}, "ui_in readback");

        // External user slots
        for (int k = 2; k < `TQV_USER_SLOTS; k++) begin
            wr_before = user_wr_count;
            size   = random_size();
            data   = $urandom;
            offset = 6'($urandom % 64);
            bus_write(11'(k << 6) | 11'(offset), data, size);
            for (int j = 2; j < `TQV_USER_SLOTS; j++) begin
                check(user_wr_count[j], wr_before[j] + ((j == k) ? 1 : 0), "slot write count");
            end
            check(user_wr_size[k], size, "slot write size");
            check(user_wr_ofs[k], offset, "slot write offset");
            rd_before = user_rd_count[k];
            bus_read(11'(k << 6), k, data, "user slot read");
            check(user_rd_count[k], rd_before + 1, "slot read count");
        end

        // Byte wide simple slots
        for (int j = 0; j < `TQV_SIMPLE_SLOTS; j++) begin
            data   = $urandom;
            offset = 6'($urandom % 16);
            bus_write(11'h400 + 11'(j * 16) + 11'(offset), data, tqv_bus_pkg::SIZE_BYTE);
            check(simple_wr_ofs[j], offset, "simple write offset");
            bus_read(11'h400 + 11'(j * 16), 1, {24'b0, data[7:0]}, "simple slot read");
        end

        // Random pin functions checked by the compare process
        for (int r = 0; r < FUNC_ROUNDS; r++) begin
            for (int n = 0; n < `TQV_PINS; n++) begin
                gpio_write(`TQV_GPIO_FUNC_OFS + 6'(4 * n), $urandom);
            end
            repeat (2) begin
                shuffle_uo();
                step();
            end
        end

        // Every audio tap with a random enable bit
        for (int c = 0; c < 8; c++) begin
            gpio_write(`TQV_GPIO_AUDIO_OFS, {28'b0, 1'($urandom % 2), 3'(c)});
            repeat (3) begin
                shuffle_uo();
                step();
            end
        end

        // Reserved slot and unused ranges
        bus_read(11'h014, 1, 32'h0, "reserved slot 0");
        bus_read(11'h2a4, 1, 32'h0, "unused range low");
        bus_read(11'h5f0, 1, 32'h0, "unused range high");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
tqv_bus_pkg.sv
tqv_pin_pkg.sv
tqv_periph_decode.sv
tqv_read_return.sv
tqv_gpio_regs.sv
tqv_pin_mux.sv
tqv_periph_wrapper.sv
tb_tqv_periph.sv

/* Bender.yml */
package:
  name: tqv_periph

sources:
  - include_dirs:
      - .
    files:
      - tqv_bus_pkg.sv
      - tqv_pin_pkg.sv
      - tqv_periph_decode.sv
      - tqv_read_return.sv
      - tqv_gpio_regs.sv
      - tqv_pin_mux.sv
      - tqv_periph_wrapper.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_tqv_periph.sv
